//--- verilog/text_video_pkg.sv
package text_video_pkg;

    // ------------------------------
    // screen geometry
    // ------------------------------
    localparam int COLS   = 80;
    localparam int ROWS   = 30;
    localparam int COL_W  = 7;
    localparam int ROW_W  = 5;
    localparam int BUF_AW = 12;    // 2400 cells

    // control register indices
    localparam logic [7:0] REG_LINE      = 8'h00;
    localparam logic [7:0] REG_CUR_X     = 8'h01;
    localparam logic [7:0] REG_CUR_Y     = 8'h02;
    localparam logic [7:0] REG_CUR_VIS   = 8'h03;
    localparam logic [7:0] REG_SCROLL_UP = 8'h04;
    localparam logic [7:0] REG_SCROLL_DN = 8'h05;
    localparam logic [7:0] REG_TTY_DATA  = 8'h06;
    localparam logic [7:0] REG_TTY_BUSY  = 8'h07;
    localparam logic [7:0] REG_CLR_EOL   = 8'h08;
    localparam logic [7:0] REG_CLR_SCR   = 8'h09;
    localparam logic [7:0] REG_TTY_EN    = 8'h0A;

    // tty control codes
    localparam logic [7:0] CH_CR = 8'h0D;
    localparam logic [7:0] CH_LF = 8'h0A;
    localparam logic [7:0] CH_BS = 8'h08;

    typedef struct packed {
        logic             is_line;    // 80-CF window
        logic [COL_W-1:0] col;
    } line_addr_t;

    // cpu address, seen as a register index or as a line-data column
    typedef union packed {
        logic [7:0] ctrl;
        line_addr_t line;
    } reg_addr_u;

    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } cell_pos_t;

    typedef struct packed {
        logic      we;
        cell_pos_t pos;    // logical row, mapped in the buffer
        logic [7:0] data;
    } buf_wr_t;

    typedef struct packed {
        logic             move_x;
        logic [COL_W-1:0] x;
        logic             move_y;
        logic [ROW_W-1:0] y;
        logic             wr_char;
        logic [7:0]       ch;
        logic             clr_eol;
        logic             clr_scr;
        logic             scroll_up;
        logic             scroll_dn;
    } tty_cmd_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [7:0] ch;    // bit 7 already flipped at the cursor
    } video_out_t;

endpackage

//--- verilog/raster_timing.sv
`timescale 1ns/1ns

module raster_timing
    import text_video_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FPORCH = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BPORCH = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FPORCH = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BPORCH = 33
)
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    output logic      hsync_o,
    output logic      vsync_o,
    output logic      de_o,
    output cell_pos_t cell_o
);

    localparam int H_TOTAL = H_SYNC + H_BPORCH + H_ACTIVE + H_FPORCH;
    localparam int V_TOTAL = V_SYNC + V_BPORCH + V_ACTIVE + V_FPORCH;
    localparam int H_START = H_SYNC + H_BPORCH;    // first visible pixel
    localparam int V_START = V_SYNC + V_BPORCH;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic [HW-1:0] h_off;
    logic [VW-1:0] v_off;
    logic          h_last;

    assign h_last = (h_cnt == HW'(H_TOTAL - 1));

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            // parked on the last pixel, both syncs idle high
            h_cnt <= HW'(H_TOTAL - 1);
            v_cnt <= VW'(V_TOTAL - 1);
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    // sync pulses open each line and frame, negative polarity
    assign hsync_o = (h_cnt >= HW'(H_SYNC));
    assign vsync_o = (v_cnt >= VW'(V_SYNC));
    assign de_o    = (h_cnt >= HW'(H_START)) && (h_cnt < HW'(H_START + H_ACTIVE))
                  && (v_cnt >= VW'(V_START)) && (v_cnt < VW'(V_START + V_ACTIVE));

    // 8x16 character cells
    assign h_off      = h_cnt - HW'(H_START);
    assign v_off      = v_cnt - VW'(V_START);
    assign cell_o.col = h_off[3 +: COL_W];
    assign cell_o.row = v_off[4 +: ROW_W];

endmodule

//--- verilog/cpu_regs.sv
`timescale 1ns/1ns

module cpu_regs
    import text_video_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  reg_addr_u  reg_addr_i,
    input  logic [7:0] data_i,
    input  logic       cs_i,
    input  logic       r_w_n_i,
    output logic [7:0] data_o,
    input  cell_pos_t  cursor_i,
    input  logic       busy_i,
    input  logic [7:0] buf_rdata_i,
    output buf_wr_t    cpu_wr_o,
    output cell_pos_t  cpu_rd_o,
    output tty_cmd_t   cmd_o,
    output logic       cursor_vis_o
);

    logic             wr_en;
    logic             line_ok;      // line-data address inside the row
    logic             line_ok_q;
    reg_addr_u        addr_q;
    logic [ROW_W-1:0] line_q;
    logic             tty_en;

    assign wr_en   = cs_i && !r_w_n_i;
    assign line_ok = reg_addr_i.line.is_line && (reg_addr_i.line.col < COL_W'(COLS));

    // ------------------------------
    // port A of the character buffer
    // ------------------------------
    assign cpu_rd_o.row  = line_q;
    assign cpu_rd_o.col  = reg_addr_i.line.col;
    assign cpu_wr_o.we   = wr_en && line_ok;
    assign cpu_wr_o.pos  = cpu_rd_o;
    assign cpu_wr_o.data = data_i;

    // ------------------------------
    // register writes and strobes
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            line_q       <= '0;
            cursor_vis_o <= 1'b1;
            tty_en       <= 1'b1;
            cmd_o        <= '0;
        end
        else
        begin
            // strobes live for one cycle
            cmd_o.move_x    <= 1'b0;
            cmd_o.move_y    <= 1'b0;
            cmd_o.wr_char   <= 1'b0;
            cmd_o.clr_eol   <= 1'b0;
            cmd_o.clr_scr   <= 1'b0;
            cmd_o.scroll_up <= 1'b0;
            cmd_o.scroll_dn <= 1'b0;
            if (wr_en)
            begin
                case (reg_addr_i.ctrl)
                    REG_LINE:      line_q <= data_i[ROW_W-1:0];
                    REG_CUR_X:
                    begin
                        cmd_o.x      <= data_i[COL_W-1:0];
                        cmd_o.move_x <= 1'b1;
                    end
                    REG_CUR_Y:
                    begin
                        cmd_o.y      <= data_i[ROW_W-1:0];
                        cmd_o.move_y <= 1'b1;
                    end
                    REG_CUR_VIS:   cursor_vis_o <= data_i[0];
                    REG_SCROLL_UP: cmd_o.scroll_up <= 1'b1;
                    REG_SCROLL_DN: cmd_o.scroll_dn <= 1'b1;
                    REG_TTY_DATA:
                    begin
                        cmd_o.ch      <= data_i;
                        cmd_o.wr_char <= tty_en;    // dropped while output is off
                    end
                    REG_CLR_EOL:   cmd_o.clr_eol <= 1'b1;
                    REG_CLR_SCR:   cmd_o.clr_scr <= 1'b1;
                    REG_TTY_EN:    tty_en <= data_i[0];
                    default: ;
                endcase
            end
        end
    end

    // read data, one cycle behind the sampled address
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            addr_q    <= '0;
            line_ok_q <= 1'b0;
            data_o    <= '0;
        end
        else
        begin
            addr_q    <= reg_addr_i;
            line_ok_q <= line_ok;
            if (line_ok_q)
                data_o <= buf_rdata_i;
            else
            begin
                case (addr_q.ctrl)
                    REG_LINE:     data_o <= 8'(line_q);
                    REG_CUR_X:    data_o <= 8'(cursor_i.col);
                    REG_CUR_Y:    data_o <= 8'(cursor_i.row);
                    REG_CUR_VIS:  data_o <= 8'(cursor_vis_o);
                    REG_TTY_BUSY: data_o <= 8'(busy_i);
                    REG_TTY_EN:   data_o <= 8'(tty_en);
                    default:      data_o <= '0;
                endcase
            end
        end
    end

endmodule

//--- verilog/tty_engine.sv
`timescale 1ns/1ns

module tty_engine
    import text_video_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  tty_cmd_t         cmd_i,
    output buf_wr_t          tty_wr_o,
    output cell_pos_t        cursor_o,
    output logic [ROW_W-1:0] start_row_o,
    output logic             busy_o
);

    typedef enum logic [2:0] {
        IDLE, WRITE_CHAR, MOVE_X, MOVE_Y,
        EOL_INIT, EOL_RUN, SCR_INIT, SCR_RUN
    } state_e;

    state_e           state;
    state_e           ret_state;      // target once a row clear is done
    logic [COL_W-1:0] clr_col;
    logic [ROW_W-1:0] clr_row;
    logic             scroll_pend;    // line feed off the bottom row
    logic             any_strobe;
    logic             is_ctrl;
    logic             at_last_col;
    logic             need_lf;

    function automatic logic [ROW_W-1:0] step_row(input logic [ROW_W-1:0] r, input logic up);
        if (up)
            return (r == ROW_W'(ROWS - 1)) ? '0 : r + 1'b1;
        return (r == '0) ? ROW_W'(ROWS - 1) : r - 1'b1;
    endfunction

    // a strobe in flight counts as busy too
    assign any_strobe = cmd_i.move_x | cmd_i.move_y | cmd_i.wr_char | cmd_i.clr_eol
                      | cmd_i.clr_scr | cmd_i.scroll_up | cmd_i.scroll_dn;
    assign busy_o     = (state != IDLE) || any_strobe;

    assign is_ctrl     = (cmd_i.ch == CH_CR) || (cmd_i.ch == CH_LF) || (cmd_i.ch == CH_BS);
    assign at_last_col = (cursor_o.col == COL_W'(COLS - 1));
    assign need_lf     = (cmd_i.ch == CH_LF) || (!is_ctrl && at_last_col);

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state       <= SCR_INIT;    // clear the buffer out of reset
            ret_state   <= IDLE;
            cursor_o    <= '0;
            start_row_o <= '0;
            clr_col     <= '0;
            clr_row     <= '0;
            scroll_pend <= 1'b0;
            tty_wr_o    <= '0;
        end
        else
        begin
            tty_wr_o.we <= 1'b0;
            case (state)
                IDLE:
                begin
                    ret_state   <= IDLE;
                    scroll_pend <= 1'b0;
                    if (cmd_i.move_x)
                        state <= MOVE_X;
                    else if (cmd_i.move_y)
                        state <= MOVE_Y;
                    else if (cmd_i.wr_char)
                        state <= WRITE_CHAR;
                    else if (cmd_i.clr_eol)
                        state <= EOL_INIT;
                    else if (cmd_i.clr_scr)
                        state <= SCR_INIT;
                    else if (cmd_i.scroll_up)
                        start_row_o <= step_row(start_row_o, 1'b1);
                    else if (cmd_i.scroll_dn)
                        start_row_o <= step_row(start_row_o, 1'b0);
                end
                WRITE_CHAR:
                begin
                    state <= IDLE;
                    if (cmd_i.ch == CH_CR)
                        cursor_o.col <= '0;
                    else if (cmd_i.ch == CH_BS)
                    begin
                        if (cursor_o.col != '0)
                        begin
                            tty_wr_o.we      <= 1'b1;
                            tty_wr_o.pos.row <= cursor_o.row;
                            tty_wr_o.pos.col <= cursor_o.col - 1'b1;
                            tty_wr_o.data    <= '0;
                            cursor_o.col     <= cursor_o.col - 1'b1;
                        end
                    end
                    else if (!is_ctrl)
                    begin
                        tty_wr_o.we   <= 1'b1;
                        tty_wr_o.pos  <= cursor_o;
                        tty_wr_o.data <= cmd_i.ch;
                        cursor_o.col  <= at_last_col ? '0 : cursor_o.col + 1'b1;
                    end
                    if (need_lf)
                    begin
                        if (cursor_o.row == ROW_W'(ROWS - 1))
                        begin
                            scroll_pend <= 1'b1;
                            state       <= EOL_INIT;
                        end
                        else
                            cursor_o.row <= cursor_o.row + 1'b1;
                    end
                end
                MOVE_X:
                begin
                    cursor_o.col <= cmd_i.x;
                    state        <= IDLE;
                end
                MOVE_Y:
                begin
                    cursor_o.row <= cmd_i.y;
                    state        <= IDLE;
                end
                // ------------------------------
                // clear from cursor x to col 79
                // ------------------------------
                EOL_INIT:
                begin
                    clr_col     <= cursor_o.col;
                    scroll_pend <= 1'b0;
                    if (scroll_pend)
                        start_row_o <= step_row(start_row_o, 1'b1);    // old top becomes bottom
                    state <= EOL_RUN;
                end
                EOL_RUN:
                begin
                    if (clr_col < COL_W'(COLS))
                    begin
                        tty_wr_o.we      <= 1'b1;
                        tty_wr_o.pos.row <= cursor_o.row;
                        tty_wr_o.pos.col <= clr_col;
                        tty_wr_o.data    <= '0;
                        clr_col          <= clr_col + 1'b1;
                    end
                    else
                        state <= ret_state;
                end
                SCR_INIT:
                begin
                    cursor_o <= '0;
                    clr_row  <= '0;
                    state    <= SCR_RUN;
                end
                SCR_RUN:
                begin
                    if (clr_row < ROW_W'(ROWS))
                    begin
                        cursor_o.row <= clr_row;    // row clear runs at the cursor
                        clr_row      <= clr_row + 1'b1;
                        ret_state    <= SCR_RUN;
                        state        <= EOL_INIT;
                    end
                    else
                    begin
                        cursor_o.row <= '0;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/screen_memory.sv
`timescale 1ns/1ns

module screen_memory
    import text_video_pkg::*;
(
    input  logic             clk_i,
    input  buf_wr_t          cpu_wr_i,
    input  cell_pos_t        cpu_rd_i,
    output logic [7:0]       cpu_rdata_o,
    input  buf_wr_t          tty_wr_i,
    input  logic [ROW_W-1:0] start_row_i,
    input  cell_pos_t        cursor_i,
    input  logic             cursor_vis_i,
    input  logic             hsync_i,
    input  logic             vsync_i,
    input  logic             de_i,
    input  cell_pos_t        disp_cell_i,
    output video_out_t       video_o
);

    logic [7:0]        mem [COLS*ROWS];
    logic [BUF_AW-1:0] addr_a;
    logic [BUF_AW-1:0] addr_b;
    logic [7:0]        disp_ch;
    logic              hs_q;
    logic              vs_q;
    logic              de_q;
    logic              cur_hit_q;

    // logical row plus scroll offset, wrapped at 30, times 80
    function automatic logic [BUF_AW-1:0] cell_addr(input cell_pos_t pos,
                                                    input logic [ROW_W-1:0] start);
        logic [ROW_W:0] sum;
        sum = pos.row + start;
        if (sum >= (ROW_W+1)'(ROWS))
            sum = sum - (ROW_W+1)'(ROWS);
        return BUF_AW'(sum) * BUF_AW'(COLS) + BUF_AW'(pos.col);
    endfunction

    assign addr_a = cell_addr(cpu_wr_i.we ? cpu_wr_i.pos : cpu_rd_i, start_row_i);
    assign addr_b = tty_wr_i.we ? cell_addr(tty_wr_i.pos, start_row_i)
                                : cell_addr(disp_cell_i, start_row_i);    // tty wins

    always_ff @(posedge clk_i)
    begin
        if (cpu_wr_i.we)
            mem[addr_a] <= cpu_wr_i.data;
        if (tty_wr_i.we)
            mem[addr_b] <= tty_wr_i.data;
        cpu_rdata_o <= mem[addr_a];
        disp_ch     <= mem[addr_b];
    end

    // ------------------------------
    // display side, aligned to the read
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        hs_q      <= hsync_i;
        vs_q      <= vsync_i;
        de_q      <= de_i;
        cur_hit_q <= cursor_vis_i && (disp_cell_i == cursor_i);
    end

    assign video_o.hsync = hs_q;
    assign video_o.vsync = vs_q;
    assign video_o.de    = de_q;
    assign video_o.ch    = {disp_ch[7] ^ cur_hit_q, disp_ch[6:0]};    // inverse cursor

endmodule

//--- verilog/text_video.sv
`timescale 1ns/1ns

module text_video
    import text_video_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FPORCH = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BPORCH = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FPORCH = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BPORCH = 33
)
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  reg_addr_u  reg_addr_i,
    input  logic [7:0] data_i,
    input  logic       cs_i,
    input  logic       r_w_n_i,
    output logic [7:0] data_o,
    output video_out_t video_o
);

    // raster side
    logic             hsync;
    logic             vsync;
    logic             de;
    cell_pos_t        disp_cell;

    // cpu and tty side
    buf_wr_t          cpu_wr;
    cell_pos_t        cpu_rd;
    logic [7:0]       cpu_rdata;
    tty_cmd_t         cmd;
    buf_wr_t          tty_wr;
    cell_pos_t        cursor;
    logic [ROW_W-1:0] start_row;
    logic             busy;
    logic             cursor_vis;

    raster_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FPORCH (H_FPORCH),
        .H_SYNC   (H_SYNC),
        .H_BPORCH (H_BPORCH),
        .V_ACTIVE (V_ACTIVE),
        .V_FPORCH (V_FPORCH),
        .V_SYNC   (V_SYNC),
        .V_BPORCH (V_BPORCH)
    ) raster_timing_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .hsync_o (hsync),
        .vsync_o (vsync),
        .de_o    (de),
        .cell_o  (disp_cell)
    );

    cpu_regs cpu_regs_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .reg_addr_i   (reg_addr_i),
        .data_i       (data_i),
        .cs_i         (cs_i),
        .r_w_n_i      (r_w_n_i),
        .data_o       (data_o),
        .cursor_i     (cursor),
        .busy_i       (busy),
        .buf_rdata_i  (cpu_rdata),
        .cpu_wr_o     (cpu_wr),
        .cpu_rd_o     (cpu_rd),
        .cmd_o        (cmd),
        .cursor_vis_o (cursor_vis)
    );

    tty_engine tty_engine_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_i       (cmd),
        .tty_wr_o    (tty_wr),
        .cursor_o    (cursor),
        .start_row_o (start_row),
        .busy_o      (busy)
    );

    screen_memory screen_memory_inst (
        .clk_i        (clk_i),
        .cpu_wr_i     (cpu_wr),
        .cpu_rd_i     (cpu_rd),
        .cpu_rdata_o  (cpu_rdata),
        .tty_wr_i     (tty_wr),
        .start_row_i  (start_row),
        .cursor_i     (cursor),
        .cursor_vis_i (cursor_vis),
        .hsync_i      (hsync),
        .vsync_i      (vsync),
        .de_i         (de),
        .disp_cell_i  (disp_cell),
        .video_o      (video_o)
    );

endmodule

//--- tb/tb_tasks.svh
// ------------------------------
// random numbers and reporting
// ------------------------------
function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
        r    = {r[14:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);    // galois step
    end
    return r;
endfunction

function automatic int rand_col();
    return int'(rand_bits(7)) % COLS;
endfunction

function automatic logic [7:0] line_addr(input int col);
    reg_addr_u a;
    a.line.is_line = 1'b1;
    a.line.col     = COL_W'(col);
    return a.ctrl;
endfunction

task automatic report_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("FAIL %s: got 0x%0h, expected 0x%0h", sig, got, exp);
    err_cnt = err_cnt + 1;
endtask

task automatic start_test();
    test_err_start = err_cnt;
    tests_run      = tests_run + 1;
endtask

task automatic finish_test(input string name);
    if (err_cnt == test_err_start)
        $display("test %0d %s: ok", tests_run, name);
    else
    begin
        $display("test %0d %s: %0d errors", tests_run, name, err_cnt - test_err_start);
        tests_failed = tests_failed + 1;
    end
endtask

// ------------------------------
// cpu bus, called 1 ns after a rising edge
// ------------------------------
task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
    reg_addr.ctrl = addr;
    data_in       = data;
    cs            = 1'b1;
    r_w_n         = 1'b0;
    @(posedge clk);
    #1;
    cs    = 1'b0;
    r_w_n = 1'b1;
endtask

task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
    reg_addr.ctrl = addr;
    cs            = 1'b1;
    r_w_n         = 1'b1;
    @(posedge clk);    // address sampled here
    #1;
    cs = 1'b0;
    @(posedge clk);
    #1;
    data = data_out;
endtask

task automatic check_read(input string what, input logic [7:0] addr, input logic [7:0] exp);
    logic [7:0] got;
    bus_read(addr, got);
    if (got !== exp)
        report_mismatch($sformatf("data_o (%s)", what), 32'(got), 32'(exp));
endtask

task automatic select_line(input int row);
    bus_write(REG_LINE, 8'(row));
endtask

task automatic check_cell(input int row, input int col, input logic [7:0] exp);
    select_line(row);
    check_read($sformatf("line %0d col %0d", row, col), line_addr(col), exp);
endtask

task automatic wait_idle();
    logic [7:0] b;
    b = 8'hFF;
    while (b !== 8'h00)
        bus_read(REG_TTY_BUSY, b);
endtask

task automatic send_char(input logic [7:0] ch);
    bus_write(REG_TTY_DATA, ch);
    wait_idle();
endtask

// video_o is sampled on the falling edge
task automatic wait_frame_start();
    logic prev_vs;
    logic found;
    found = 1'b0;
    @(negedge clk);
    prev_vs = video.vsync;
    while (!found)
    begin
        @(negedge clk);
        found   = (prev_vs === 1'b1) && (video.vsync === 1'b0);
        prev_vs = video.vsync;
    end
endtask

task automatic first_frame_cell(output logic [7:0] ch);
    wait_frame_start();
    while (video.de !== 1'b1)
        @(negedge clk);
    ch = video.ch;
    @(posedge clk);
    #1;
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic reset_clear_test();
    int cols [4];
    start_test();
    wait_idle();
    check_read("cursor x", REG_CUR_X, 8'h00);
    check_read("cursor y", REG_CUR_Y, 8'h00);
    // dirty some cells and move the cursor, then clear on command
    for (int i = 0; i < 4; i++)
    begin
        cols[i] = rand_col();
        select_line(0);
        bus_write(line_addr(cols[i]), 8'hA5);
        select_line(ROWS - 1);
        bus_write(line_addr(cols[i]), 8'h5A);
    end
    bus_write(REG_CUR_X, 8'd7);
    wait_idle();
    bus_write(REG_CUR_Y, 8'd3);
    wait_idle();
    bus_write(REG_CLR_SCR, 8'h00);
    wait_idle();
    check_read("cursor x", REG_CUR_X, 8'h00);
    check_read("cursor y", REG_CUR_Y, 8'h00);
    for (int i = 0; i < 4; i++)
    begin
        check_cell(0, cols[i], 8'h00);
        check_cell(ROWS - 1, cols[i], 8'h00);
    end
    finish_test("reset clear");
endtask

task automatic regs_readback_test();
    logic [7:0] model [COLS];
    int         cols_used [8];
    int         row;
    logic [7:0] val;
    start_test();
    foreach (model[i])
        model[i] = 8'h00;    // screen is blank after reset
    row = int'(rand_bits(5)) % ROWS;
    select_line(row);
    for (int i = 0; i < 8; i++)
    begin
        cols_used[i]        = rand_col();
        val                 = 8'(rand_bits(8));
        model[cols_used[i]] = val;    // a repeated column keeps the last byte
        bus_write(line_addr(cols_used[i]), val);
    end
    for (int i = 0; i < 8; i++)
        check_read($sformatf("line %0d col %0d", row, cols_used[i]),
                   line_addr(cols_used[i]), model[cols_used[i]]);
    check_read("line register", REG_LINE, 8'(row));
    check_read("cursor visible", REG_CUR_VIS, 8'h01);
    bus_write(REG_CUR_VIS, 8'h00);
    check_read("cursor visible", REG_CUR_VIS, 8'h00);
    bus_write(REG_CUR_VIS, 8'h01);
    check_read("unused register 0B", 8'h0B, 8'h00);
    check_read("line address past col 79", line_addr(COLS), 8'h00);
    finish_test("register readback");
endtask

task automatic tty_text_test();
    int col;
    start_test();
    send_char(8'h41);
    send_char(8'h42);
    check_read("cursor x", REG_CUR_X, 8'h02);
    check_cell(0, 0, 8'h41);
    check_cell(0, 1, 8'h42);
    send_char(CH_BS);
    check_read("cursor x", REG_CUR_X, 8'h01);
    check_cell(0, 1, 8'h00);
    send_char(CH_CR);
    check_read("cursor x", REG_CUR_X, 8'h00);
    for (int i = 0; i < COLS; i++)
        send_char(8'h20 + 8'(i));    // one full row, then wrap
    check_read("cursor y", REG_CUR_Y, 8'h01);
    check_read("cursor x", REG_CUR_X, 8'h00);
    for (int i = 0; i < 4; i++)
    begin
        col = rand_col();
        check_cell(0, col, 8'h20 + 8'(col));
    end
    finish_test("tty text");
endtask

task automatic scrolling_test();
    logic [7:0] marker;
    logic [7:0] exp;
    start_test();
    marker = 8'(rand_bits(8)) | 8'h01;
    select_line(1);
    for (int c = 0; c < COLS; c++)
        bus_write(line_addr(c), marker);
    bus_write(REG_CUR_Y, 8'(ROWS - 1));
    wait_idle();
    bus_write(REG_CUR_X, 8'd10);
    wait_idle();
    send_char(CH_LF);    // off the bottom, screen moves up
    check_read("cursor y", REG_CUR_Y, 8'(ROWS - 1));
    check_read("cursor x", REG_CUR_X, 8'd10);
    select_line(0);
    for (int c = 0; c < COLS; c++)
        check_read($sformatf("line 0 col %0d", c), line_addr(c), marker);
    // old top row comes back as the bottom, blanked from col 10
    select_line(ROWS - 1);
    for (int c = 0; c < COLS; c++)
    begin
        exp = (c < 10) ? 8'h20 + 8'(c) : 8'h00;
        check_read($sformatf("line %0d col %0d", ROWS - 1, c), line_addr(c), exp);
    end
    bus_write(REG_SCROLL_DN, 8'h00);
    wait_idle();
    select_line(1);
    for (int c = 0; c < COLS; c++)
        check_read($sformatf("line 1 col %0d", c), line_addr(c), marker);
    finish_test("scrolling");
endtask

task automatic raster_timing_test();
    video_out_t v;
    int         hs_run;
    int         de_run;
    int         hs_pulses;
    int         hs_bad;
    int         de_lines;
    int         de_bad;
    int         vs_low;
    start_test();
    hs_run    = 0;
    de_run    = 0;
    hs_pulses = 0;
    hs_bad    = 0;
    de_lines  = 0;
    de_bad    = 0;
    vs_low    = 0;
    wait_frame_start();
    for (int i = 0; i < FRAME_CYCLES; i++)
    begin
        if (i != 0)
            @(negedge clk);
        v = video;
        if (!v.hsync)
            hs_run = hs_run + 1;
        else if (hs_run != 0)
        begin
            hs_bad    = hs_bad + ((hs_run != H_SYNC) ? 1 : 0);
            hs_pulses = hs_pulses + 1;
            hs_run    = 0;
        end
        if (v.de)
            de_run = de_run + 1;
        else if (de_run != 0)
        begin
            de_bad   = de_bad + ((de_run != H_ACTIVE) ? 1 : 0);
            de_lines = de_lines + 1;
            de_run   = 0;
        end
        if (!v.vsync)
            vs_low = vs_low + 1;
    end
    if (hs_pulses != V_TOTAL)
        report_mismatch("video_o.hsync pulses per frame", 32'(hs_pulses), 32'(V_TOTAL));
    if (hs_bad != 0)
        report_mismatch("video_o.hsync pulses of wrong width", 32'(hs_bad), 32'h0);
    if (de_lines != V_ACTIVE)
        report_mismatch("video_o.de active lines", 32'(de_lines), 32'(V_ACTIVE));
    if (de_bad != 0)
        report_mismatch("video_o.de lines of wrong width", 32'(de_bad), 32'h0);
    if (vs_low != V_SYNC * H_TOTAL)
        report_mismatch("video_o.vsync low cycles", 32'(vs_low), 32'(V_SYNC * H_TOTAL));
    @(posedge clk);
    #1;
    finish_test("raster timing");
endtask

task automatic cursor_cell_test();
    logic [7:0] ch;
    start_test();
    bus_write(REG_CUR_X, 8'h00);
    wait_idle();
    bus_write(REG_CUR_Y, 8'h00);
    wait_idle();
    bus_write(REG_CUR_VIS, 8'h01);
    select_line(0);
    bus_write(line_addr(0), 8'h41);
    first_frame_cell(ch);
    if (ch !== 8'hC1)    // inverse video at the cursor
        report_mismatch("video_o.ch cursor on", 32'(ch), 32'hC1);
    bus_write(REG_CUR_VIS, 8'h00);
    first_frame_cell(ch);
    if (ch !== 8'h41)
        report_mismatch("video_o.ch cursor off", 32'(ch), 32'h41);
    finish_test("cell output and cursor");
endtask

//--- tb/tb_text_video.sv
`timescale 1ns/1ns

module tb_text_video
    import text_video_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FPORCH = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BPORCH = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FPORCH = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BPORCH = 33
);

    localparam int H_TOTAL      = H_SYNC + H_BPORCH + H_ACTIVE + H_FPORCH;
    localparam int V_TOTAL      = V_SYNC + V_BPORCH + V_ACTIVE + V_FPORCH;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLEAR_CYCLES = ROWS * (COLS + 4);    // full screen clear
    localparam int FIRST_DE     = (V_SYNC + V_BPORCH) * H_TOTAL + H_SYNC + H_BPORCH;
    // up to two frames per video test, the wait for the first visible cell,
    // a few clears, and the bus traffic
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 2 * FIRST_DE + 3 * CLEAR_CYCLES + 20000;

    logic       clk;
    logic       rst_n;
    reg_addr_u  reg_addr;
    logic [7:0] data_in;
    logic       cs;
    logic       r_w_n;
    logic [7:0] data_out;
    video_out_t video;

    logic [15:0] lfsr;
    int          err_cnt;
    int          test_err_start;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;

    text_video #(
        .H_ACTIVE (H_ACTIVE),
        .H_FPORCH (H_FPORCH),
        .H_SYNC   (H_SYNC),
        .H_BPORCH (H_BPORCH),
        .V_ACTIVE (V_ACTIVE),
        .V_FPORCH (V_FPORCH),
        .V_SYNC   (V_SYNC),
        .V_BPORCH (V_BPORCH)
    ) text_video_inst (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .reg_addr_i (reg_addr),
        .data_i     (data_in),
        .cs_i       (cs),
        .r_w_n_i    (r_w_n),
        .data_o     (data_out),
        .video_o    (video)
    );

    `include "tb_tasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 50 MHz
    end

    // ------------------------------
    // run limit
    // ------------------------------
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: no result after %0d cycles, DUT stuck busy or video not running",
                 TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        reg_addr     = '0;
        data_in      = 8'h00;
        cs           = 1'b0;
        r_w_n        = 1'b1;
        rst_n        = 1'b0;
        lfsr         = 16'd62;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        reset_clear_test();
        regs_readback_test();
        tty_text_test();
        scrolling_test();
        raster_timing_test();
        cursor_cell_test();

        $display("%0d tests run, %0d failed, %0d failed checks",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+tb
verilog/text_video_pkg.sv
verilog/raster_timing.sv
verilog/cpu_regs.sv
verilog/tty_engine.sv
verilog/screen_memory.sv
verilog/text_video.sv
tb/tb_text_video.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_text_video
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard tb/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)
